// File: rtl/isa_pkg.sv
package isa_pkg;

    // ----------------------------------------
    // Load/store funct3 field
    // ----------------------------------------
    typedef logic [2:0] funct3_t;    // ir[14:12]

    // Size field in funct3[1:0]
    localparam logic [1:0] F3_SZ_BYTE = 2'b00;
    localparam logic [1:0] F3_SZ_HALF = 2'b01;
    localparam logic [1:0] F3_SZ_WORD = 2'b10;

    // Full encodings, loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;    // Zero extend
    localparam funct3_t F3_LHU = 3'b101;    // Zero extend

    // Stores share the size field, bit 2 never set
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // Encoding 11 has no RV32 meaning, treated as word
    function automatic access_size_e decode_size(input funct3_t f3);
        case (f3[1:0])
            F3_SZ_BYTE: return SIZE_BYTE;
            F3_SZ_HALF: return SIZE_HALF;
            default:    return SIZE_WORD;
        endcase
    endfunction

    function automatic logic is_unsigned(input funct3_t f3);
        return f3[2];    // Only meaningful for loads
    endfunction

endpackage

// File: rtl/mem_pkg.sv
package mem_pkg;

    // ----------------------------------------
    // Data path widths
    // ----------------------------------------
    localparam int DATA_WIDTH = 32;    // One RAM word
    localparam int BYTE_W     = 8;
    localparam int HALF_W     = 16;

    // Lanes per word and low address bits that pick them
    localparam int NUM_LANES  = DATA_WIDTH / BYTE_W;
    localparam int LANE_BITS  = $clog2(NUM_LANES);

    // ----------------------------------------
    // Memory geometry
    // ----------------------------------------
    // Word address bits, RAM holds 2**ADDR_BITS words
    localparam int DEFAULT_ADDR_BITS = 8;

    // Byte address is word address plus lane bits
    function automatic int byte_addr_bits(input int addr_bits);
        return addr_bits + LANE_BITS;
    endfunction

endpackage

// File: rtl/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if #(
    parameter int ADDR_BITS = mem_pkg::DEFAULT_ADDR_BITS
);
    import mem_pkg::*;

    logic [ADDR_BITS-1:0]  addr;     // Word address
    logic [DATA_WIDTH-1:0] wdata;    // Merged store word
    logic                  we;       // Active high
    logic [DATA_WIDTH-1:0] rdata;    // Follows addr, no latency

    // Access unit side
    modport ctrl (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // Storage side
    modport ram (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: rtl/word_memory.sv
`timescale 1ns/1ps

module word_memory #(
    parameter int ADDR_BITS = mem_pkg::DEFAULT_ADDR_BITS
) (
    input logic  clk_i,    // Rising edge
    mem_bus_if.ram bus_o
);
    import mem_pkg::*;

    // ----------------------------------------
    // Storage array
    // ----------------------------------------
    localparam int DEPTH = 2 ** ADDR_BITS;

    // N words x DATA_WIDTH, contents undefined at power up
    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    // Write port
    // Full word only, lane merge done upstream
    always_ff @(posedge clk_i) begin
        if (bus_o.we) begin
            mem_q[bus_o.addr] <= bus_o.wdata;
        end
    end

    // Read port
    // Asynchronous so a load completes in its own cycle
    assign bus_o.rdata = mem_q[bus_o.addr];

endmodule

// File: rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [mem_pkg::DATA_WIDTH-1:0] word_i,      // Raw word from RAM
    input  logic [1:0]                     lane_i,      // byte_addr[1:0]
    input  isa_pkg::access_size_e          size_i,
    input  logic                           unsigned_i,  // 1 = zero extend
    output logic [mem_pkg::DATA_WIDTH-1:0] data_o
);
    import mem_pkg::*;
    import isa_pkg::*;

    logic [BYTE_W-1:0] byte_sel;
    logic [HALF_W-1:0] half_sel;
    logic              fill;       // Extension bit

    // ----------------------------------------
    // Lane select
    // ----------------------------------------
    always_comb begin
        case (lane_i)
            2'd0:    byte_sel = word_i[BYTE_W-1:0];
            2'd1:    byte_sel = word_i[2*BYTE_W-1:BYTE_W];
            2'd2:    byte_sel = word_i[3*BYTE_W-1:2*BYTE_W];
            default: byte_sel = word_i[4*BYTE_W-1:3*BYTE_W];
        endcase
    end

    // Halfword picked by bit 1 only
    assign half_sel = lane_i[1] ? word_i[DATA_WIDTH-1:HALF_W] : word_i[HALF_W-1:0];

    // ----------------------------------------
    // Sign or zero extension
    // ----------------------------------------
    always_comb begin
        fill = 1'b0;
        if (!unsigned_i) begin
            // Top bit of the selected lane
            fill = (size_i == SIZE_BYTE) ? byte_sel[BYTE_W-1] : half_sel[HALF_W-1];
        end

        case (size_i)
            SIZE_BYTE: data_o = {{(DATA_WIDTH-BYTE_W){fill}}, byte_sel};
            SIZE_HALF: data_o = {{(DATA_WIDTH-HALF_W){fill}}, half_sel};
            default:   data_o = word_i;    // Whole word unchanged
        endcase
    end

endmodule

// File: rtl/store_merge.sv
`timescale 1ns/1ps

module store_merge (
    input  logic [mem_pkg::DATA_WIDTH-1:0] old_word_i,  // Current RAM contents
    input  logic [mem_pkg::DATA_WIDTH-1:0] wd_i,        // Store data, lane in low bits
    input  logic [1:0]                     lane_i,
    input  isa_pkg::access_size_e          size_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] word_o
);
    import mem_pkg::*;
    import isa_pkg::*;

    logic [BYTE_W-1:0]     new_byte;
    logic [HALF_W-1:0]     new_half;
    logic [DATA_WIDTH-1:0] byte_word;    // Old word with one byte replaced
    logic [DATA_WIDTH-1:0] half_word;    // Old word with one half replaced

    assign new_byte = wd_i[BYTE_W-1:0];
    assign new_half = wd_i[HALF_W-1:0];

    // ----------------------------------------
    // Byte merge
    // ----------------------------------------
    always_comb begin
        case (lane_i)
            2'd0:    byte_word = {old_word_i[DATA_WIDTH-1:BYTE_W], new_byte};
            2'd1:    byte_word = {old_word_i[DATA_WIDTH-1:2*BYTE_W], new_byte,
                                  old_word_i[BYTE_W-1:0]};
            2'd2:    byte_word = {old_word_i[DATA_WIDTH-1:3*BYTE_W], new_byte,
                                  old_word_i[2*BYTE_W-1:0]};
            default: byte_word = {new_byte, old_word_i[3*BYTE_W-1:0]};
        endcase
    end

    // Halfword merge, lane bit 1 picks upper or lower
    assign half_word = lane_i[1] ? {new_half, old_word_i[HALF_W-1:0]}
                                 : {old_word_i[DATA_WIDTH-1:HALF_W], new_half};

    // ----------------------------------------
    // Size select
    // ----------------------------------------
    always_comb begin
        case (size_i)
            SIZE_BYTE: word_o = byte_word;
            SIZE_HALF: word_o = half_word;
            default:   word_o = wd_i;    // Word store overwrites all lanes
        endcase
    end

endmodule

// File: rtl/pmmu.sv
`timescale 1ns/1ps

module pmmu #(
    parameter int ADDR_BITS = mem_pkg::DEFAULT_ADDR_BITS
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  isa_pkg::funct3_t               funct3_i,     // ir[14:12]
    input  logic [ADDR_BITS+1:0]           byte_addr_i,  // Byte addressing
    input  logic [mem_pkg::DATA_WIDTH-1:0] wd_i,
    input  logic                           mwr_n_i,      // Write strobe, active low
    input  logic                           mrd_n_i,      // Read strobe, active low
    output logic [mem_pkg::DATA_WIDTH-1:0] rd_o,
    output logic                           misaligned_o,
    output logic                           fault_o,      // Sticky until reset
    mem_bus_if.ctrl                        bus
);
    import mem_pkg::*;
    import isa_pkg::*;

    access_size_e          size;
    logic                  uns;
    logic [1:0]            lane;
    logic                  addr_bad;     // Address not on a size boundary
    logic                  access;       // Any strobe active
    logic [DATA_WIDTH-1:0] load_data;
    logic [DATA_WIDTH-1:0] merged_word;
    logic                  fault_q;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign size   = decode_size(funct3_i);
    assign uns    = is_unsigned(funct3_i);
    assign lane   = byte_addr_i[1:0];
    assign access = ~mwr_n_i | ~mrd_n_i;

    // Alignment check
    always_comb begin
        case (size)
            SIZE_HALF: addr_bad = lane[0];
            SIZE_WORD: addr_bad = |lane;
            default:   addr_bad = 1'b0;    // Bytes always aligned
        endcase
    end

    assign misaligned_o = access & addr_bad;

    // ----------------------------------------
    // RAM side
    // ----------------------------------------
    // Drop lane bits for word addressing
    assign bus.addr  = byte_addr_i[ADDR_BITS+1:2];
    assign bus.wdata = merged_word;
    assign bus.we    = ~mwr_n_i & ~addr_bad;    // Misaligned store is dropped

    // Read-modify-write in one cycle
    store_merge u_store_merge (
        .old_word_i (bus.rdata),
        .wd_i       (wd_i),
        .lane_i     (lane),
        .size_i     (size),
        .word_o     (merged_word)
    );

    load_align u_load_align (
        .word_i     (bus.rdata),
        .lane_i     (lane),
        .size_i     (size),
        .unsigned_i (uns),
        .data_o     (load_data)
    );

    // Raw word when no read is requested
    assign rd_o = mrd_n_i ? bus.rdata : load_data;

    // ----------------------------------------
    // Sticky fault
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fault_q <= 1'b0;
        end else if (misaligned_o) begin
            fault_q <= 1'b1;    // Held until next reset
        end
    end

    assign fault_o = fault_q;

endmodule

// File: rtl/data_mem_top.sv
`timescale 1ns/1ps

module data_mem_top #(
    parameter int ADDR_BITS = mem_pkg::DEFAULT_ADDR_BITS    // Word address bits
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  isa_pkg::funct3_t               funct3_i,
    input  logic [ADDR_BITS+1:0]           byte_addr_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] wd_i,
    input  logic                           mwr_n_i,       // Active low
    input  logic                           mrd_n_i,       // Active low
    output logic [mem_pkg::DATA_WIDTH-1:0] rd_o,
    output logic                           misaligned_o,
    output logic                           fault_o
);

    // ----------------------------------------
    // Access unit to RAM link
    // ----------------------------------------
    mem_bus_if #(
        .ADDR_BITS (ADDR_BITS)
    ) u_bus ();

    // Decode, alignment, lane handling
    pmmu #(
        .ADDR_BITS (ADDR_BITS)
    ) u_pmmu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .funct3_i     (funct3_i),
        .byte_addr_i  (byte_addr_i),
        .wd_i         (wd_i),
        .mwr_n_i      (mwr_n_i),
        .mrd_n_i      (mrd_n_i),
        .rd_o         (rd_o),
        .misaligned_o (misaligned_o),
        .fault_o      (fault_o),
        .bus          (u_bus.ctrl)
    );

    // Word storage, 2**ADDR_BITS entries
    word_memory #(
        .ADDR_BITS (ADDR_BITS)
    ) u_word_memory (
        .clk_i (clk_i),
        .bus_o (u_bus.ram)
    );

endmodule

// File: verification/data_mem_properties.sv
`timescale 1ns/1ps

module data_mem_properties (
    input logic clk_i,
    input logic arst_n_i,
    input logic we_i,            // RAM write enable
    input logic misaligned_i,
    input logic fault_i
);

    // ----------------------------------------
    // Write suppression
    // ----------------------------------------
    no_write_on_misaligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) misaligned_i |-> !we_i
    ) else $error("RAM write enable high during a misaligned access");

    // ----------------------------------------
    // Sticky fault
    // ----------------------------------------
    fault_never_falls: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !$fell(fault_i)
    ) else $error("fault_o dropped without a reset");

    // One edge after the access
    fault_follows_misaligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) misaligned_i |=> fault_i
    ) else $error("fault_o not set after a misaligned access");

endmodule

bind pmmu data_mem_properties u_properties (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .we_i         (bus.we),
    .misaligned_i (misaligned_o),
    .fault_i      (fault_o)
);

// File: verification/data_mem_tb.sv
`timescale 1ns/1ps

module data_mem_tb;
    import isa_pkg::*;
    import mem_pkg::*;

    localparam int ADDR_BITS  = 6;                // 64 words only
    localparam int AW         = ADDR_BITS + 2;    // Byte address width
    localparam int DEPTH      = 2 ** ADDR_BITS;
    localparam int RAND_OPS   = 400;
    localparam int WAIT_LIMIT = 10;               // Cycles before a wait gives up

    // One access per row
    typedef struct packed {
        logic                  is_store;
        funct3_t               f3;
        logic [AW-1:0]         addr;
        logic [DATA_WIDTH-1:0] wd;
        logic [DATA_WIDTH-1:0] exp_rd;     // Loads only
        logic                  exp_mis;
    } row_t;

    logic                  clk;
    logic                  arst_n;
    funct3_t               funct3;
    logic [AW-1:0]         byte_addr;
    logic [DATA_WIDTH-1:0] wd;
    logic                  mwr_n;
    logic                  mrd_n;
    logic [DATA_WIDTH-1:0] rd;
    logic                  misaligned;
    logic                  fault;

    row_t                  rows[$];
    logic [DATA_WIDTH-1:0] ref_mem [DEPTH];    // Reference copy of the RAM
    logic                  exp_fault;
    int                    error_count;
    integer                seed;

    data_mem_top #(
        .ADDR_BITS (ADDR_BITS)
    ) dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .funct3_i     (funct3),
        .byte_addr_i  (byte_addr),
        .wd_i         (wd),
        .mwr_n_i      (mwr_n),
        .mrd_n_i      (mrd_n),
        .rd_o         (rd),
        .misaligned_o (misaligned),
        .fault_o      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 100 MHz
    end

    // ----------------------------------------
    // Reference rules
    // ----------------------------------------
    function automatic logic addr_misaligned(input funct3_t f3, input logic [1:0] lane);
        case (f3[1:0])
            2'b00:   return 1'b0;              // Byte
            2'b01:   return lane[0];           // Half
            default: return lane != 2'b00;     // Word
        endcase
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] w, input funct3_t f3,
                                                input logic [1:0] lane);
        logic [31:0] shifted;
        shifted = w >> (8 * lane);    // Addressed lane to bit 0
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
            2'b01:   return f3[2] ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] expect_merge(input logic [31:0] old, input logic [31:0] data,
                                                 input funct3_t f3, input logic [1:0] lane);
        logic [31:0] mask;
        case (f3[1:0])
            2'b00:   mask = 32'h0000_00FF << (8 * lane);
            2'b01:   mask = 32'h0000_FFFF << (8 * lane);
            default: mask = 32'hFFFF_FFFF;
        endcase
        return (old & ~mask) | ((data << (8 * lane)) & mask);
    endfunction

    // ----------------------------------------
    // Checking and driving
    // ----------------------------------------
    task automatic stop_run();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic add_row(input logic st, input funct3_t f3, input logic [AW-1:0] addr,
                           input logic [31:0] data, input logic [31:0] exp_rd, input logic mis);
        rows.push_back('{st, f3, addr, data, exp_rd, mis});
    endtask

    task automatic set_idle();
        mwr_n = 1'b1;
        mrd_n = 1'b1;
    endtask

    task automatic drive_access(input logic is_store, input funct3_t f3,
                                input logic [AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        funct3    = f3;
        byte_addr = addr;
        wd        = data;
        mwr_n     = ~is_store;
        mrd_n     = is_store;
        #4;    // Mid cycle with outputs settled
    endtask

    // Let a pending store commit and drop strobes
    task automatic finish_access();
        @(posedge clk);
        #1;
        set_idle();
    endtask

    task automatic check_outputs(input logic is_store, input logic [31:0] exp_rd,
                                 input logic exp_mis);
        check_value("misaligned_o", misaligned, exp_mis);
        check_value("fault_o", fault, exp_fault);
        if (!is_store && !exp_mis) begin
            check_value("rd_o", rd, exp_rd);
        end
        if (exp_mis) begin
            exp_fault = 1'b1;    // Visible after next edge
        end
    endtask

    task automatic apply_reset();
        set_idle();
        funct3    = F3_LW;
        byte_addr = AW'(8'h03);    // Misaligned word address with no strobe
        arst_n    = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n    = 1'b1;
        exp_fault = 1'b0;
        check_value("fault_o", fault, 1'b0);
        check_value("misaligned_o", misaligned, 1'b0);    // No strobe active
    endtask

    task automatic wait_fault_rise(output int edges);
        edges = 0;
        while (fault !== 1'b1) begin
            if (edges >= WAIT_LIMIT) begin
                $display("Timeout: fault_o did not rise after a misaligned access");
                stop_run();
            end
            @(posedge clk);
            #1;
            edges++;
        end
    endtask

    // ----------------------------------------
    // Directed table
    // ----------------------------------------
    task automatic build_table();
        // st    funct3  addr                      wd            exp_rd        mis
        add_row(1'b1, F3_SW,  AW'(8'h00),              32'h1234_5678, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h00),              32'h0,         32'h1234_5678, 1'b0);
        add_row(1'b1, F3_SW,  AW'(8'h40),              32'hCAFE_F00D, 32'h0,         1'b0);
        add_row(1'b1, F3_SW,  AW'((DEPTH - 1) * 4),    32'hDEAD_BEEF, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h40),              32'h0,         32'hCAFE_F00D, 1'b0);
        add_row(1'b0, F3_LW,  AW'((DEPTH - 1) * 4),    32'h0,         32'hDEAD_BEEF, 1'b0);
        // Byte lanes one at a time
        add_row(1'b1, F3_SW,  AW'(8'h10),              32'h1122_3344, 32'h0,         1'b0);
        add_row(1'b1, F3_SB,  AW'(8'h10),              32'hFFFF_FFA5, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h10),              32'h0,         32'h1122_33A5, 1'b0);
        add_row(1'b1, F3_SB,  AW'(8'h11),              32'h0000_00B6, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h10),              32'h0,         32'h1122_B6A5, 1'b0);
        add_row(1'b1, F3_SB,  AW'(8'h12),              32'h0000_007C, 32'h0,         1'b0);
        add_row(1'b1, F3_SB,  AW'(8'h13),              32'h0000_0080, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h10),              32'h0,         32'h807C_B6A5, 1'b0);
        // Sign and zero extension
        add_row(1'b0, F3_LB,  AW'(8'h10),              32'h0,         32'hFFFF_FFA5, 1'b0);
        add_row(1'b0, F3_LBU, AW'(8'h10),              32'h0,         32'h0000_00A5, 1'b0);
        add_row(1'b0, F3_LB,  AW'(8'h12),              32'h0,         32'h0000_007C, 1'b0);
        add_row(1'b0, F3_LBU, AW'(8'h12),              32'h0,         32'h0000_007C, 1'b0);
        add_row(1'b0, F3_LBU, AW'(8'h13),              32'h0,         32'h0000_0080, 1'b0);
        add_row(1'b0, F3_LB,  AW'(8'h13),              32'h0,         32'hFFFF_FF80, 1'b0);
        add_row(1'b0, F3_LH,  AW'(8'h10),              32'h0,         32'hFFFF_B6A5, 1'b0);
        add_row(1'b0, F3_LHU, AW'(8'h12),              32'h0,         32'h0000_807C, 1'b0);
        add_row(1'b0, F3_LH,  AW'(8'h12),              32'h0,         32'hFFFF_807C, 1'b0);
        add_row(1'b0, F3_LH,  AW'(8'h02),              32'h0,         32'h0000_1234, 1'b0);
        add_row(1'b0, F3_LHU, AW'(8'h00),              32'h0,         32'h0000_5678, 1'b0);
        // Misaligned stores must not write
        add_row(1'b1, F3_SH,  AW'(8'h41),              32'h0000_FFFF, 32'h0,         1'b1);
        add_row(1'b1, F3_SW,  AW'(8'h42),              32'h0000_0000, 32'h0,         1'b1);
        add_row(1'b0, F3_LW,  AW'(8'h40),              32'h0,         32'hCAFE_F00D, 1'b0);
        add_row(1'b1, F3_SH,  AW'(8'h03),              32'h0000_AAAA, 32'h0,         1'b1);
        add_row(1'b0, F3_LW,  AW'(8'h00),              32'h0,         32'h1234_5678, 1'b0);
        add_row(1'b1, F3_SH,  AW'(8'h42),              32'h0000_BEEF, 32'h0,         1'b0);
        add_row(1'b0, F3_LW,  AW'(8'h40),              32'h0,         32'hBEEF_F00D, 1'b0);
    endtask

    task automatic run_table();
        foreach (rows[i]) begin
            drive_access(rows[i].is_store, rows[i].f3, rows[i].addr, rows[i].wd);
            check_outputs(rows[i].is_store, rows[i].exp_rd, rows[i].exp_mis);
        end
        finish_access();
    endtask

    // Fault must rise exactly one edge after a misaligned access
    task automatic check_fault_timing();
        int edges;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("fault_o", fault, 1'b0);
        end
        drive_access(1'b0, F3_LH, AW'(8'h41), 32'h0);    // Odd halfword address
        check_value("misaligned_o", misaligned, 1'b1);
        check_value("fault_o", fault, 1'b0);
        wait_fault_rise(edges);
        assert (edges == 1) else begin
            $display("fault_o rose %0d edges after the misaligned access, not one", edges);
            stop_run();
        end
        exp_fault = 1'b1;
        finish_access();
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("fault_o", fault, 1'b1);    // Sticky
        end
    endtask

    // ----------------------------------------
    // Random phase
    // ----------------------------------------
    task automatic run_random();
        logic [31:0]   rnd;
        logic          is_store;
        funct3_t       f3;
        logic [AW-1:0] addr;
        logic [31:0]   data;
        logic          mis;
        int            idx;
        // Known contents in every word first
        for (int i = 0; i < DEPTH; i++) begin
            data = $random(seed);
            drive_access(1'b1, F3_SW, AW'(i * 4), data);
            check_outputs(1'b1, 32'h0, 1'b0);
            ref_mem[i] = data;
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd      = $random(seed);
            is_store = rnd[0];
            f3[1:0]  = 2'(rnd[31:8] % 3);
            f3[2]    = ~rnd[0] & rnd[1] & (f3[1:0] != 2'b10);    // Unsigned loads only
            addr     = AW'($random(seed));
            data     = $random(seed);
            idx      = int'(addr[AW-1:2]);
            mis      = addr_misaligned(f3, addr[1:0]);
            drive_access(is_store, f3, addr, data);
            check_outputs(is_store, expect_load(ref_mem[idx], f3, addr[1:0]), mis);
            if (is_store) begin
                check_value("rd_o", rd, ref_mem[idx]);    // Raw old word without read strobe
            end
            if (is_store && !mis) begin
                ref_mem[idx] = expect_merge(ref_mem[idx], data, f3, addr[1:0]);
            end
        end
        finish_access();
    endtask

    initial begin
        seed        = 79;
        error_count = 0;
        exp_fault   = 1'b0;
        arst_n      = 1'b0;
        funct3      = F3_LW;
        byte_addr   = '0;
        wd          = '0;
        mwr_n       = 1'b1;
        mrd_n       = 1'b1;
        build_table();
        apply_reset();
        run_table();
        apply_reset();          // Fault clears while RAM keeps its words
        check_fault_timing();
        run_random();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: data_mem.f
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/word_memory.sv
rtl/load_align.sv
rtl/store_merge.sv
rtl/pmmu.sv
rtl/data_mem_top.sv
verification/data_mem_properties.sv
verification/data_mem_tb.sv

// File: Bender.yml
package:
  name: data_mem

sources:
  # Design, in compile order
  - rtl/isa_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/mem_bus_if.sv
  - rtl/word_memory.sv
  - rtl/load_align.sv
  - rtl/store_merge.sv
  - rtl/pmmu.sv
  - rtl/data_mem_top.sv

  # Verification
  - target: test
    files:
      - verification/data_mem_properties.sv
      - verification/data_mem_tb.sv
